// File: source/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // one copy of the banked storage per read port
  localparam int NUMRDPT = 2;
  localparam int WIDTH = 16;

  localparam int NUMVBNK = 4;
  localparam int BITVBNK = 2;
  localparam int NUMVROW = 16;
  localparam int BITVROW = 4;

  localparam int NUMADDR = NUMVBNK * NUMVROW;
  localparam int BITADDR = 6;

  // physical address is the bank index followed by the row index
  localparam int BITPADR = BITVBNK + BITVROW;

  // cycles from a read strobe to its data
  localparam int SRAM_DELAY = 2;

  typedef logic [BITADDR-1:0] addr_t;
  typedef logic [BITVBNK-1:0] bank_t;
  typedef logic [BITVROW-1:0] row_t;
  typedef logic [BITPADR-1:0] padr_t;
  typedef logic [WIDTH-1:0] data_t;

  typedef enum logic [1:0] {
    ST_RESET,
    ST_CLEAR,
    ST_READY
  } init_state_t;

endpackage

`default_nettype wire

// File: source/init_row_counter.sv
`timescale 1ns/1ps
`default_nettype none

module init_row_counter (
  input  wire clk,
  input  wire rst,
  input  wire cnt_clr,
  input  wire cnt_en,
  output mem_pkg::row_t row,
  output logic last
);

  assign last = (row == mem_pkg::row_t'(mem_pkg::NUMVROW - 1));

  // the count parks on the last row so a late enable cannot wrap it
  always_ff @(posedge clk) begin
    if (rst || cnt_clr) begin
      row <= '0;
    end else if (cnt_en && !last) begin
      row <= row + 1'b1;
    end
  end

  // enable has to end with the last row, the sweep never starts over
  a_no_wrap: assert property (
    @(posedge clk) disable iff (rst)
    (cnt_en && last) |=> !cnt_en
  ) else $error("init row counter still enabled after the last row");

endmodule

`default_nettype wire

// File: source/mem_init_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module mem_init_fsm (
  input  wire clk,
  input  wire rst,
  input  wire last,
  output logic cnt_clr,
  output logic cnt_en,
  output logic clr_write,
  output logic ready
);

  mem_pkg::init_state_t state;
  mem_pkg::init_state_t state_nxt;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= mem_pkg::ST_RESET;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      mem_pkg::ST_RESET: begin
        state_nxt = mem_pkg::ST_CLEAR;
      end
      mem_pkg::ST_CLEAR: begin
        // the last row is cleared in this same cycle
        if (last) begin
          state_nxt = mem_pkg::ST_READY;
        end
      end
      mem_pkg::ST_READY: begin
        state_nxt = mem_pkg::ST_READY;
      end
      default: begin
        state_nxt = mem_pkg::ST_RESET;
      end
    endcase
  end

  assign cnt_clr = (state == mem_pkg::ST_RESET);
  assign cnt_en = (state == mem_pkg::ST_CLEAR);
  assign clr_write = (state == mem_pkg::ST_CLEAR);
  assign ready = (state == mem_pkg::ST_READY);

  a_ready_excl_clear: assert property (
    @(posedge clk) disable iff (rst)
    !(ready && clr_write)
  ) else $error("ready raised while rows are still being cleared");

endmodule

`default_nettype wire

// File: source/bank_addr_map.sv
`timescale 1ns/1ps
`default_nettype none

module bank_addr_map (
  input  wire mem_pkg::addr_t adr,
  output mem_pkg::bank_t bank,
  output mem_pkg::row_t row,
  output mem_pkg::padr_t padr
);

  // low-order interleave, consecutive addresses land in consecutive banks
  always_comb begin
    bank = mem_pkg::bank_t'(adr % mem_pkg::NUMVBNK);
    row = mem_pkg::row_t'(adr / mem_pkg::NUMVBNK);
  end

  assign padr = {bank, row};

  // an idle port may carry an undriven address
  always_comb begin
    if (!$isunknown(adr)) begin
      assert (adr < mem_pkg::NUMADDR)
        else $error("address %0d beyond memory depth", adr);
    end
  end

endmodule

`default_nettype wire

// File: source/bank_copy.sv
`timescale 1ns/1ps
`default_nettype none

module bank_copy (
  input  wire clk,
  input  wire clr_all,
  input  wire wr_en,
  input  wire mem_pkg::bank_t wr_bank,
  input  wire mem_pkg::row_t wr_row,
  input  wire mem_pkg::data_t wr_data,
  input  wire rd_en,
  input  wire mem_pkg::bank_t rd_bank,
  input  wire mem_pkg::row_t rd_row,
  output mem_pkg::data_t rd_data
);

  mem_pkg::data_t mem [mem_pkg::NUMVBNK][mem_pkg::NUMVROW];

  // stage 0 is the array read, the rest model the macro latency
  mem_pkg::data_t rd_pipe [mem_pkg::SRAM_DELAY];

  always_ff @(posedge clk) begin
    if (clr_all) begin
      // one row index in every bank per cycle
      for (int b = 0; b < mem_pkg::NUMVBNK; b++) begin
        mem[b][wr_row] <= '0;
      end
    end else if (wr_en) begin
      mem[wr_bank][wr_row] <= wr_data;
    end
  end

  // nonblocking read sees the word from before a same-edge write
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_pipe[0] <= mem[rd_bank][rd_row];
    end
    for (int i = 1; i < mem_pkg::SRAM_DELAY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign rd_data = rd_pipe[mem_pkg::SRAM_DELAY-1];

endmodule

`default_nettype wire

// File: source/nr1w_dup_core.sv
`timescale 1ns/1ps
`default_nettype none

module nr1w_dup_core (
  input  wire clk,
  input  wire rst,
  input  wire ready,
  input  wire clr_write,
  input  wire mem_pkg::row_t clr_row,
  input  wire write,
  input  wire mem_pkg::addr_t wr_adr,
  input  wire mem_pkg::data_t din,
  input  wire [mem_pkg::NUMRDPT-1:0] read,
  input  wire mem_pkg::addr_t [mem_pkg::NUMRDPT-1:0] rd_adr,
  output wire [mem_pkg::NUMRDPT-1:0] rd_vld,
  output wire mem_pkg::data_t [mem_pkg::NUMRDPT-1:0] rd_dout,
  output wire mem_pkg::padr_t [mem_pkg::NUMRDPT-1:0] rd_padr
);

  logic write_g;
  logic [mem_pkg::NUMRDPT-1:0] read_g;

  mem_pkg::bank_t wr_bank;
  mem_pkg::row_t wr_row;
  mem_pkg::row_t cp_wr_row;

  // user strobes count only once initialization is done
  assign write_g = write && ready;
  assign read_g = read & {mem_pkg::NUMRDPT{ready}};

  bank_addr_map u_wr_map (
    .adr  (wr_adr),
    .bank (wr_bank),
    .row  (wr_row),
    .padr ()
  );

  // while clearing, the row comes from the init counter
  assign cp_wr_row = clr_write ? clr_row : wr_row;

  for (genvar p = 0; p < mem_pkg::NUMRDPT; p++) begin : g_port
    mem_pkg::bank_t rd_bank;
    mem_pkg::row_t rd_row;
    mem_pkg::padr_t rd_padr_map;
    logic [mem_pkg::SRAM_DELAY-1:0] vld_pipe;
    mem_pkg::padr_t padr_pipe [mem_pkg::SRAM_DELAY];

    bank_addr_map u_rd_map (
      .adr  (rd_adr[p]),
      .bank (rd_bank),
      .row  (rd_row),
      .padr (rd_padr_map)
    );

    // every copy takes the same write, so all copies stay identical
    bank_copy u_copy (
      .clk     (clk),
      .clr_all (clr_write),
      .wr_en   (write_g),
      .wr_bank (wr_bank),
      .wr_row  (cp_wr_row),
      .wr_data (din),
      .rd_en   (read_g[p]),
      .rd_bank (rd_bank),
      .rd_row  (rd_row),
      .rd_data (rd_dout[p])
    );

    always_ff @(posedge clk) begin
      if (rst) begin
        vld_pipe <= '0;
      end else begin
        vld_pipe[0] <= read_g[p];
        for (int i = 1; i < mem_pkg::SRAM_DELAY; i++) begin
          vld_pipe[i] <= vld_pipe[i-1];
        end
      end
    end

    always_ff @(posedge clk) begin
      padr_pipe[0] <= rd_padr_map;
      for (int i = 1; i < mem_pkg::SRAM_DELAY; i++) begin
        padr_pipe[i] <= padr_pipe[i-1];
      end
    end

    assign rd_vld[p] = vld_pipe[mem_pkg::SRAM_DELAY-1];
    assign rd_padr[p] = padr_pipe[mem_pkg::SRAM_DELAY-1];

    a_rd_latency: assert property (
      @(posedge clk) disable iff (rst)
      read_g[p] |-> ##(mem_pkg::SRAM_DELAY) rd_vld[p]
    ) else $error("port %0d read did not return after fixed latency", p);
  end

  a_no_vld_when_idle: assert property (
    @(posedge clk) disable iff (rst)
    (!ready)[*mem_pkg::SRAM_DELAY] |=> (rd_vld == '0)
  ) else $error("read valid seen without a ready read in flight");

endmodule

`default_nettype wire

// File: source/nr1w_dup_top.sv
`timescale 1ns/1ps
`default_nettype none

module nr1w_dup_top (
  input  wire clk,
  input  wire rst,
  input  wire write,
  input  wire mem_pkg::addr_t wr_adr,
  input  wire mem_pkg::data_t din,
  input  wire [mem_pkg::NUMRDPT-1:0] read,
  input  wire mem_pkg::addr_t [mem_pkg::NUMRDPT-1:0] rd_adr,
  output wire ready,
  output wire [mem_pkg::NUMRDPT-1:0] rd_vld,
  output wire mem_pkg::data_t [mem_pkg::NUMRDPT-1:0] rd_dout,
  output wire mem_pkg::padr_t [mem_pkg::NUMRDPT-1:0] rd_padr
);

  wire cnt_clr;
  wire cnt_en;
  wire clr_write;
  wire last;
  mem_pkg::row_t init_row;

  mem_init_fsm u_init_fsm (
    .clk       (clk),
    .rst       (rst),
    .last      (last),
    .cnt_clr   (cnt_clr),
    .cnt_en    (cnt_en),
    .clr_write (clr_write),
    .ready     (ready)
  );

  init_row_counter u_row_cnt (
    .clk     (clk),
    .rst     (rst),
    .cnt_clr (cnt_clr),
    .cnt_en  (cnt_en),
    .row     (init_row),
    .last    (last)
  );

  nr1w_dup_core u_core (
    .clk       (clk),
    .rst       (rst),
    .ready     (ready),
    .clr_write (clr_write),
    .clr_row   (init_row),
    .write     (write),
    .wr_adr    (wr_adr),
    .din       (din),
    .read      (read),
    .rd_adr    (rd_adr),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout),
    .rd_padr   (rd_padr)
  );

endmodule

`default_nettype wire

// File: testbench/nr1w_dup_tb.sv
`timescale 1ns/1ps
`default_nettype none

module nr1w_dup_tb;

  localparam int NUMRDPT = mem_pkg::NUMRDPT;
  localparam int SRAM_DELAY = mem_pkg::SRAM_DELAY;
  localparam int MAX_ROWS = 48;

  typedef mem_pkg::addr_t [NUMRDPT-1:0] addr_vec_t;
  typedef mem_pkg::data_t [NUMRDPT-1:0] dout_vec_t;
  typedef mem_pkg::padr_t [NUMRDPT-1:0] padr_vec_t;

  logic clk;
  logic rst;
  logic write;
  mem_pkg::addr_t wr_adr;
  mem_pkg::data_t din;
  logic [NUMRDPT-1:0] read;
  addr_vec_t rd_adr;
  wire ready;
  wire [NUMRDPT-1:0] rd_vld;
  dout_vec_t rd_dout;
  padr_vec_t rd_padr;

  // stimulus table, one row per cycle once the memory is ready
  string tbl_name [MAX_ROWS];
  logic tbl_write [MAX_ROWS];
  mem_pkg::addr_t tbl_wr_adr [MAX_ROWS];
  mem_pkg::data_t tbl_din [MAX_ROWS];
  logic [NUMRDPT-1:0] tbl_read [MAX_ROWS];
  addr_vec_t tbl_rd_adr [MAX_ROWS];
  int num_rows;

  // contents the memory should hold after initialization and each accepted write
  mem_pkg::data_t mirror [mem_pkg::NUMADDR];

  int q_idx [$];
  logic [NUMRDPT-1:0] q_vld [$];
  dout_vec_t q_dout [$];
  padr_vec_t q_padr [$];

  int cur_idx;
  int checks;
  int errors;
  int cycle_count;
  int timeout_limit;
  int seed_val;
  int low_edges;

  nr1w_dup_top uut (
    .clk     (clk),
    .rst     (rst),
    .write   (write),
    .wr_adr  (wr_adr),
    .din     (din),
    .read    (read),
    .rd_adr  (rd_adr),
    .ready   (ready),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout),
    .rd_padr (rd_padr)
  );

  always #4 clk = ~clk;

  task automatic check_value(input string test, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Mismatch %s %s: expected %0h, actual %0h", test, what, expected, actual);
    end
  endtask

  task automatic add_row(input string name, input logic wr, input int wadr,
                         input logic [NUMRDPT-1:0] rmask, input int radr0, input int radr1);
    if (num_rows >= MAX_ROWS) begin
      errors++;
      $display("stimulus table is full, row %s was not added", name);
    end else begin
      tbl_name[num_rows] = name;
      tbl_write[num_rows] = wr;
      tbl_wr_adr[num_rows] = mem_pkg::addr_t'(wadr);
      tbl_din[num_rows] = mem_pkg::data_t'($urandom);
      tbl_read[num_rows] = rmask;
      tbl_rd_adr[num_rows][0] = mem_pkg::addr_t'(radr0);
      tbl_rd_adr[num_rows][1] = mem_pkg::addr_t'(radr1);
      num_rows++;
    end
  endtask

  function automatic string row_name(input int idx);
    if (idx == -1) begin
      return "gating";
    end else if (idx < 0) begin
      return "drain";
    end
    return tbl_name[idx];
  endfunction

  // bank is the address modulo the bank count, row the quotient
  function automatic int expected_padr(input int adr);
    return (adr % mem_pkg::NUMVBNK) * mem_pkg::NUMVROW + adr / mem_pkg::NUMVBNK;
  endfunction

  task automatic build_table();
    add_row("init_zero", 1'b0, 0, 2'b11, 0, 1);
    add_row("init_zero", 1'b0, 0, 2'b11, 2, 3);
    add_row("init_zero", 1'b0, 0, 2'b11, 9, 62);
    add_row("init_zero", 1'b0, 0, 2'b11, 63, 4);
    add_row("write_read", 1'b1, 5, 2'b00, 0, 0);
    add_row("write_read", 1'b1, 10, 2'b11, 5, 5);
    add_row("write_read", 1'b1, 47, 2'b11, 10, 10);
    add_row("write_read", 1'b0, 0, 2'b11, 47, 47);
    add_row("indep_ports", 1'b1, 20, 2'b00, 0, 0);
    add_row("indep_ports", 1'b1, 21, 2'b00, 0, 0);
    add_row("indep_ports", 1'b1, 22, 2'b00, 0, 0);
    add_row("indep_ports", 1'b1, 23, 2'b00, 0, 0);
    add_row("indep_ports", 1'b0, 0, 2'b11, 20, 21);
    add_row("indep_ports", 1'b0, 0, 2'b11, 22, 23);
    add_row("indep_ports", 1'b0, 0, 2'b11, 23, 20);
    add_row("indep_ports", 1'b0, 0, 2'b11, 21, 22);
    add_row("indep_ports", 1'b0, 0, 2'b01, 20, 0);
    add_row("indep_ports", 1'b0, 0, 2'b10, 0, 23);
    add_row("collision", 1'b1, 30, 2'b00, 0, 0);
    add_row("collision", 1'b1, 30, 2'b11, 30, 30);
    add_row("collision", 1'b0, 0, 2'b11, 30, 30);
    add_row("phys_addr", 1'b1, 7, 2'b00, 0, 0);
    add_row("phys_addr", 1'b1, 34, 2'b00, 0, 0);
    add_row("phys_addr", 1'b0, 0, 2'b11, 7, 13);
    add_row("phys_addr", 1'b0, 0, 2'b11, 34, 49);
    add_row("phys_addr", 1'b0, 0, 2'b11, 58, 63);
    add_row("phys_addr", 1'b0, 0, 2'b11, 1, 44);
  endtask

  // ready is due NUMVROW plus 1 edges after the first edge with reset low
  always @(posedge clk) begin
    if (rst) begin
      low_edges = 0;
    end else if (low_edges <= mem_pkg::NUMVROW) begin
      low_edges++;
    end
  end

  // inputs are stable at the falling edge and outputs have settled
  always @(negedge clk) begin : scoreboard
    int idx;
    logic exp_ready;
    logic [NUMRDPT-1:0] e_vld;
    dout_vec_t e_dout;
    padr_vec_t e_padr;
    if (q_vld.size() == SRAM_DELAY) begin
      idx = q_idx.pop_front();
      e_vld = q_vld.pop_front();
      e_dout = q_dout.pop_front();
      e_padr = q_padr.pop_front();
      for (int p = 0; p < NUMRDPT; p++) begin
        check_value(row_name(idx), $sformatf("rd_vld[%0d]", p), e_vld[p], rd_vld[p]);
        if (e_vld[p]) begin
          check_value(row_name(idx), $sformatf("rd_dout[%0d]", p), e_dout[p], rd_dout[p]);
          check_value(row_name(idx), $sformatf("rd_padr[%0d]", p), e_padr[p], rd_padr[p]);
        end
      end
    end
    exp_ready = (low_edges > mem_pkg::NUMVROW);
    // the DUT samples these strobes at the next rising edge, reads before the write
    for (int p = 0; p < NUMRDPT; p++) begin
      e_vld[p] = exp_ready && read[p];
      e_dout[p] = mirror[rd_adr[p]];
      e_padr[p] = mem_pkg::padr_t'(expected_padr(int'(rd_adr[p])));
    end
    q_idx.push_back(cur_idx);
    q_vld.push_back(e_vld);
    q_dout.push_back(e_dout);
    q_padr.push_back(e_padr);
    if (exp_ready && write) begin
      mirror[wr_adr] = din;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_limit) begin
      $display("timeout after %0d cycles, the run did not reach its end", timeout_limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin
    int init_cycles;
    logic ready_seen;
    clk = 1'b0;
    rst = 1'b1;
    write = 1'b0;
    wr_adr = '0;
    din = '0;
    read = '0;
    rd_adr = '0;
    cur_idx = -1;
    checks = 0;
    errors = 0;
    cycle_count = 0;
    low_edges = 0;
    num_rows = 0;
    seed_val = $urandom(44075);
    for (int a = 0; a < mem_pkg::NUMADDR; a++) begin
      mirror[a] = '0;
    end
    build_table();
    timeout_limit = mem_pkg::NUMVROW + num_rows + SRAM_DELAY + 20;

    // strobes during reset and early initialization must be dropped
    @(posedge clk);
    write <= 1'b1;
    wr_adr <= mem_pkg::addr_t'(9);
    din <= 16'hbeef;
    read <= '1;
    rd_adr <= {mem_pkg::addr_t'(2), mem_pkg::addr_t'(9)};
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // first edge with reset low
    @(posedge clk);
    init_cycles = 0;
    ready_seen = 1'b0;
    while (!ready_seen) begin
      @(negedge clk);
      init_cycles++;
      ready_seen = ready;
      if (init_cycles == mem_pkg::NUMVROW / 2) begin
        @(posedge clk);
        write <= 1'b0;
        read <= '0;
      end
    end
    check_value("init_ready", "ready latency", mem_pkg::NUMVROW + 1, init_cycles);

    for (int i = 0; i < num_rows; i++) begin
      @(posedge clk);
      cur_idx <= i;
      write <= tbl_write[i];
      wr_adr <= tbl_wr_adr[i];
      din <= tbl_din[i];
      read <= tbl_read[i];
      rd_adr <= tbl_rd_adr[i];
    end
    @(posedge clk);
    cur_idx <= -2;
    write <= 1'b0;
    read <= '0;
    repeat (SRAM_DELAY + 2) @(negedge clk);
    @(posedge clk);

    $display("checks run %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
source/mem_pkg.sv
source/init_row_counter.sv
source/mem_init_fsm.sv
source/bank_addr_map.sv
source/bank_copy.sv
source/nr1w_dup_core.sv
source/nr1w_dup_top.sv
testbench/nr1w_dup_tb.sv

// File: Bender.yml
package:
  name: nr1w_dup

sources:
  - source/mem_pkg.sv
  - source/init_row_counter.sv
  - source/mem_init_fsm.sv
  - source/bank_addr_map.sv
  - source/bank_copy.sv
  - source/nr1w_dup_core.sv
  - source/nr1w_dup_top.sv
  - target: test
    files:
      - testbench/nr1w_dup_tb.sv
